// File: life_consts.svh
// Grid geometry, pipeline latencies and counter widths
// for the cell address sequencer
`ifndef LIFE_CONSTS_SVH
`define LIFE_CONSTS_SVH

////////////////////////////////////////////////////////////
// Grid of cell blocks
////////////////////////////////////////////////////////////

`define LIFE_BLOCKS_WIDE 16 // Block columns, one nibble
`define LIFE_BLOCKS_HIGH 10 // Logical block rows

// Last read count of one generation
`define LIFE_DONE_COUNT 159

// Spare store row for logical row 0 on odd base
`define LIFE_ODD_ROW0 15

////////////////////////////////////////////////////////////
// Latencies
////////////////////////////////////////////////////////////

`define LIFE_WRITE_DELAY 6 // Read window to write-back
`define LIFE_LOAD_DELAY  5 // video_load to ld

////////////////////////////////////////////////////////////
// Counters
////////////////////////////////////////////////////////////

`define LIFE_GEN_W 48 // Total generations

`endif

// File: life_pkg.sv
// Shared types of the cell address sequencer
// Row, column, store address, read window, counter, phase
`default_nettype none

package life_pkg;

	// Row and column index of a block
	typedef logic [3:0] row_t;
	typedef logic [3:0] col_t;

	// Store address, row in [7:4] and column in [3:0]
	typedef logic [7:0] cell_addr_t;

	// 3x3 neighbourhood of read addresses
	// Outer index row-1, row, row+1
	// Inner index col-1, col, col+1
	typedef cell_addr_t [2:0][2:0] cell_win_t;

	// Completed generations
	typedef logic [47:0] gen_count_t;

	// Sequencer phase
	typedef enum logic [0:0] {
		SEQ_IDLE,
		SEQ_RUN
	} seq_phase_e;

endpackage

`default_nettype wire

// File: gen_sequencer.sv
// Generation sequencer: read counter over the block grid,
// rotating base row and total generation counter
`timescale 1ns/1ns
`default_nettype none

`include "life_consts.svh"

module gen_sequencer (
	input  wire logic               clk4,
	input  wire logic               reset,
	input  wire logic               go,        // One shot or held for back to back
	output      logic               rd_valid,
	output      life_pkg::cell_addr_t rd_cell, // Row in [7:4], column in [3:0]
	output      life_pkg::row_t     rd_base,
	output      life_pkg::gen_count_t gen_count
);

	life_pkg::seq_phase_e phase;
	life_pkg::cell_addr_t count;
	life_pkg::row_t       base;
	logic                 last_read; // Final block of this generation
	logic                 gen_tick;

	assign last_read = (phase == life_pkg::SEQ_RUN) &&
		(count == life_pkg::cell_addr_t'(`LIFE_DONE_COUNT));

	////////////////////////////////////////////////////////////
	// Read counter and phase FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk4) begin
		if (reset) begin
			phase <= life_pkg::SEQ_IDLE;
			count <= '0;
			base  <= life_pkg::row_t'(1); // Row 0 starts in spare row 15
		end else begin
			case (phase)
				life_pkg::SEQ_IDLE: begin
					if (go) begin
						phase <= life_pkg::SEQ_RUN;
						count <= '0;
					end
				end
				life_pkg::SEQ_RUN: begin
					if (last_read) begin
						count <= '0;
						phase <= go ? life_pkg::SEQ_RUN : life_pkg::SEQ_IDLE; // Restart if held
						// Rotate base once per generation
						base  <= (base == life_pkg::row_t'(`LIFE_BLOCKS_HIGH - 1)) ?
							'0 : base + 4'd1;
					end else begin
						count <= count + 8'd1;
					end
				end
				default: phase <= life_pkg::SEQ_IDLE;
			endcase
		end
	end

	assign rd_valid = (phase == life_pkg::SEQ_RUN);
	assign rd_cell  = count;
	assign rd_base  = base;

	////////////////////////////////////////////////////////////
	// Generation counter
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk4) begin
		if (reset) begin
			gen_tick  <= 1'b0;
			gen_count <= '0;
		end else begin
			gen_tick <= last_read; // One cycle after count 159
			if (gen_tick)
				gen_count <= gen_count + `LIFE_GEN_W'(1);
		end
	end

	// Base only ever names a logical row
	a_base_range: assert property (@(posedge clk4) disable iff (reset)
		base < life_pkg::row_t'(`LIFE_BLOCKS_HIGH));

	// Counter wraps at the grid end, never past it
	a_count_range: assert property (@(posedge clk4) disable iff (reset)
		(phase == life_pkg::SEQ_RUN) |-> count <= life_pkg::cell_addr_t'(`LIFE_DONE_COUNT));

endmodule

`default_nettype wire

// File: cell_addr_pipe.sv
// Four-stage row and column mapping pipeline for the 3x3 read window
// and write address, plus the video load strobe delay
`timescale 1ns/1ns
`default_nettype none

`include "life_consts.svh"

module cell_addr_pipe (
	input  wire logic                 clk4,
	input  wire logic                 rd_valid,
	input  wire life_pkg::cell_addr_t rd_cell,
	input  wire life_pkg::row_t       rd_base,
	input  wire life_pkg::cell_addr_t video_addr, // Block read while idle
	input  wire logic                 video_load,
	output      life_pkg::cell_win_t  raddr,
	output      life_pkg::cell_addr_t pipe_waddr,
	output      logic                 pipe_wvalid,
	output      logic                 ld
);

	life_pkg::row_t rd_row;
	life_pkg::col_t rd_col;
	life_pkg::row_t wr_base; // Base of the next generation

	assign rd_row  = rd_cell[7:4];
	assign rd_col  = rd_cell[3:0];
	assign wr_base = (rd_base == life_pkg::row_t'(`LIFE_BLOCKS_HIGH - 1)) ?
		'0 : rd_base + 4'd1;

	////////////////////////////////////////////////////////////
	// Row lanes: 0 above, 1 centre, 2 below, 3 write
	////////////////////////////////////////////////////////////

	life_pkg::row_t [3:0] sel_row;  // Stage 1
	life_pkg::row_t [3:0] sel_base;
	logic [3:0]           zero_q;   // Stage 2
	logic [3:0]           odd_q;
	logic [3:0][4:0]      diff_q;   // Signed row - base
	logic [3:0]           zero_qq;  // Stage 3
	logic [3:0]           odd_qq;
	life_pkg::row_t [3:0] mod_row;
	life_pkg::row_t [3:0] map_row;  // Stage 4, store rows

	always_ff @(posedge clk4) begin
		// Stage 1, lane select with top and bottom wrap
		sel_row[0]  <= (rd_row == '0) ? life_pkg::row_t'(`LIFE_BLOCKS_HIGH - 1) : rd_row - 4'd1;
		sel_row[1]  <= rd_valid ? rd_row : video_addr[7:4]; // Video when idle
		sel_row[2]  <= (rd_row == life_pkg::row_t'(`LIFE_BLOCKS_HIGH - 1)) ?
			'0 : rd_row + 4'd1;
		sel_row[3]  <= rd_row;
		sel_base[0] <= rd_base;
		sel_base[1] <= rd_base;
		sel_base[2] <= rd_base;
		sel_base[3] <= wr_base; // Written into next generation's layout
		for (int i = 0; i < 4; i++) begin
			// Stage 2
			zero_q[i]  <= (sel_row[i] == '0);
			odd_q[i]   <= sel_base[i][0];
			diff_q[i]  <= {1'b0, sel_row[i]} - {1'b0, sel_base[i]};
			// Stage 3, fold d <= 0 up by ten
			zero_qq[i] <= zero_q[i];
			odd_qq[i]  <= odd_q[i];
			if (diff_q[i][4] || diff_q[i] == 5'd0)
				mod_row[i] <= life_pkg::row_t'(diff_q[i] + 5'(`LIFE_BLOCKS_HIGH));
			else
				mod_row[i] <= diff_q[i][3:0];
			// Stage 4, row 0 lives in 0 or the spare row
			if (zero_qq[i])
				map_row[i] <= odd_qq[i] ? life_pkg::row_t'(`LIFE_ODD_ROW0) : '0;
			else
				map_row[i] <= mod_row[i];
		end
	end

	////////////////////////////////////////////////////////////
	// Column path, matched to the row lanes
	////////////////////////////////////////////////////////////

	life_pkg::col_t       col_sel;
	life_pkg::col_t       col_d1;
	life_pkg::col_t       col_d2;
	life_pkg::col_t [2:0] nb_col; // col-1, col, col+1

	always_ff @(posedge clk4) begin
		col_sel   <= rd_valid ? rd_col : video_addr[3:0];
		col_d1    <= col_sel;
		col_d2    <= col_d1;
		// Side wrap
		nb_col[0] <= (col_d2 == '0) ? life_pkg::col_t'(`LIFE_BLOCKS_WIDE - 1) : col_d2 - 4'd1;
		nb_col[1] <= col_d2;
		nb_col[2] <= (col_d2 == life_pkg::col_t'(`LIFE_BLOCKS_WIDE - 1)) ?
			'0 : col_d2 + 4'd1;
	end

	// Nine read addresses
	always_comb begin
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++)
				raddr[r][c] = {map_row[r], nb_col[c]};
		end
	end

	assign pipe_waddr = {map_row[3], nb_col[1]};

	////////////////////////////////////////////////////////////
	// Side strobes
	////////////////////////////////////////////////////////////

	logic [3:0]                    valid_line; // Follows the row stages
	logic [`LIFE_LOAD_DELAY-1:0]   load_line;

	always_ff @(posedge clk4) begin
		valid_line <= {valid_line[2:0], rd_valid};
		load_line  <= {load_line[`LIFE_LOAD_DELAY-2:0], video_load};
	end

	assign pipe_wvalid = valid_line[3];
	assign ld          = load_line[`LIFE_LOAD_DELAY-1]; // Block data ready for video

	// Generation traffic only ever lands in rows 0..10 or the spare
	for (genvar g = 0; g < 4; g++) begin : g_row_chk
		a_row_range: assert property (@(posedge clk4)
			pipe_wvalid |-> (map_row[g] <= life_pkg::row_t'(`LIFE_BLOCKS_HIGH) ||
				map_row[g] == life_pkg::row_t'(`LIFE_ODD_ROW0)));
	end

endmodule

`default_nettype wire

// File: cell_write_sched.sv
// Write-back scheduler, delay line for write address and enable
`timescale 1ns/1ns
`default_nettype none

`include "life_consts.svh"

module cell_write_sched (
	input  wire logic                 clk4,
	input  wire logic                 reset,
	input  wire life_pkg::cell_addr_t pipe_waddr,
	input  wire logic                 pipe_wvalid,
	output      life_pkg::cell_addr_t waddr,
	output      logic                 we
);

	////////////////////////////////////////////////////////////
	// Delay line, one entry per cycle of cell calculation
	////////////////////////////////////////////////////////////

	life_pkg::cell_addr_t [`LIFE_WRITE_DELAY-1:0] addr_line;
	logic [`LIFE_WRITE_DELAY-1:0]                 we_line;

	// Address payload, no reset
	always_ff @(posedge clk4) begin
		addr_line <= {addr_line[`LIFE_WRITE_DELAY-2:0], pipe_waddr};
	end

	always_ff @(posedge clk4) begin
		if (reset)
			we_line <= '0;
		else
			we_line <= {we_line[`LIFE_WRITE_DELAY-2:0], pipe_wvalid};
	end

	assign waddr = addr_line[`LIFE_WRITE_DELAY-1];
	assign we    = we_line[`LIFE_WRITE_DELAY-1]; // Result of the read window lands here

	// No stray write while the line refills after reset
	a_quiet_after_reset: assert property (@(posedge clk4)
		$fell(reset) |-> !we [*`LIFE_WRITE_DELAY]);

endmodule

`default_nettype wire

// File: life_addr_ctrl.sv
// Cell address and control sequencer top
// Sequencer, mapping pipeline and write-back scheduler
`timescale 1ns/1ns
`default_nettype none

module life_addr_ctrl (
	input  wire logic                 clk4,
	input  wire logic                 reset,
	input  wire logic                 go,
	input  wire life_pkg::cell_addr_t video_addr,
	input  wire logic                 video_load,
	output      life_pkg::cell_win_t  raddr,
	output      life_pkg::cell_addr_t waddr,
	output      logic                 we,
	output      logic                 ld,
	output      life_pkg::gen_count_t gen_count
);

	logic                 rd_valid;
	life_pkg::cell_addr_t rd_cell;
	life_pkg::row_t       rd_base;
	life_pkg::cell_addr_t pipe_waddr;
	logic                 pipe_wvalid;

	gen_sequencer u_seq (
		.clk4      (clk4),
		.reset     (reset),
		.go        (go),
		.rd_valid  (rd_valid),
		.rd_cell   (rd_cell),
		.rd_base   (rd_base),
		.gen_count (gen_count)
	);

	cell_addr_pipe u_pipe (
		.clk4        (clk4),
		.rd_valid    (rd_valid),
		.rd_cell     (rd_cell),
		.rd_base     (rd_base),
		.video_addr  (video_addr),
		.video_load  (video_load),
		.raddr       (raddr),
		.pipe_waddr  (pipe_waddr),
		.pipe_wvalid (pipe_wvalid),
		.ld          (ld)
	);

	cell_write_sched u_wsched (
		.clk4        (clk4),
		.reset       (reset),
		.pipe_waddr  (pipe_waddr),
		.pipe_wvalid (pipe_wvalid),
		.waddr       (waddr),
		.we          (we)
	);

endmodule

`default_nettype wire

// File: tb_life_addr_ctrl.sv
// Testbench for the cell address sequencer: clock, LFSR stimulus,
// sequencer and mapping reference, delayed output comparison
`timescale 1ns/1ns
`default_nettype none

`include "life_consts.svh"

module tb_life_addr_ctrl;

	localparam int CYCLE_LIMIT = 3000; // Scripted run is about 760 cycles
	localparam int READ_LAT    = 4;    // Count to raddr
	localparam int WRITE_LAT   = READ_LAT + `LIFE_WRITE_DELAY;

	logic                 clk4 = 1'b0;
	logic                 reset;
	logic                 go;
	life_pkg::cell_addr_t video_addr;
	logic                 video_load;
	life_pkg::cell_win_t  raddr;
	life_pkg::cell_addr_t waddr;
	logic                 we;
	logic                 ld;
	life_pkg::gen_count_t gen_count;

	// Reference sequencer, state after the last edge
	life_pkg::seq_phase_e m_phase  = life_pkg::SEQ_IDLE;
	logic [7:0]           m_count  = '0;
	life_pkg::row_t       m_base   = 4'd1;
	logic                 m_tick   = 1'b0;
	life_pkg::gen_count_t m_gen    = '0;
	logic                 go_seen  = 1'b0; // Inputs as that edge saw them
	logic                 rst_seen = 1'b1;

	life_pkg::cell_win_t win_q[$]; // Expected raddr
	logic [8:0]          wr_q[$];  // Expected {we, waddr}
	logic                ld_q[$];  // Expected ld

	int          out_errors = 0;
	int          seq_errors = 0;
	int          checks     = 0;
	int          wr_count   = 0;
	int          ld_count   = 0;
	int          cycles     = 0;
	logic [15:0] lfsr       = 16'd25000;

	life_addr_ctrl i_dut (
		.clk4       (clk4),
		.reset      (reset),
		.go         (go),
		.video_addr (video_addr),
		.video_load (video_load),
		.raddr      (raddr),
		.waddr      (waddr),
		.we         (we),
		.ld         (ld),
		.gen_count  (gen_count)
	);

	initial begin
		forever #20 clk4 = ~clk4; // 40 ns period
	end

	////////////////////////////////////////////////////////////
	// Random bits and reference mapping
	////////////////////////////////////////////////////////////

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rand_byte(output logic [7:0] v);
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr); // One step per bit
			v[i] = lfsr[0];
		end
	endtask

	// Store row of logical row r under base b
	function automatic life_pkg::row_t store_row(input int r, input int b);
		int d;
		if (r == 0)
			return (b % 2 == 1) ? life_pkg::row_t'(`LIFE_ODD_ROW0) : life_pkg::row_t'(0);
		d = r - b;
		return life_pkg::row_t'((d <= 0) ? d + `LIFE_BLOCKS_HIGH : d);
	endfunction

	function automatic life_pkg::cell_win_t ref_window(input logic [7:0] cnt,
		input life_pkg::row_t base, input logic run, input life_pkg::cell_addr_t vaddr);
		life_pkg::cell_win_t w;
		int row;
		int col;
		int nrow [3];
		row     = int'(cnt[7:4]);
		col     = run ? int'(cnt[3:0]) : int'(vaddr[3:0]); // Video centre when idle
		nrow[0] = (row == 0) ? `LIFE_BLOCKS_HIGH - 1 : row - 1;
		nrow[1] = run ? row : int'(vaddr[7:4]);
		nrow[2] = (row == `LIFE_BLOCKS_HIGH - 1) ? 0 : row + 1;
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++)
				w[i][j] = {store_row(nrow[i], int'(base)),
					life_pkg::col_t'((col + j - 1 + `LIFE_BLOCKS_WIDE) % `LIFE_BLOCKS_WIDE)};
		end
		return w;
	endfunction

	// Write lands in the next generation's layout
	function automatic life_pkg::cell_addr_t ref_waddr(input logic [7:0] cnt,
		input life_pkg::row_t base);
		int nb;
		nb = (int'(base) + 1) % `LIFE_BLOCKS_HIGH;
		return {store_row(int'(cnt[7:4]), nb), cnt[3:0]};
	endfunction

	task automatic step_model();
		logic last;
		last = (m_phase == life_pkg::SEQ_RUN) && (m_count == 8'(`LIFE_DONE_COUNT));
		if (rst_seen) begin
			m_phase = life_pkg::SEQ_IDLE;
			m_count = '0;
			m_base  = 4'd1;
			m_tick  = 1'b0;
			m_gen   = '0;
		end else begin
			if (m_tick)
				m_gen = m_gen + 48'd1;
			m_tick = last; // Count lags the last read by two edges
			if (m_phase == life_pkg::SEQ_IDLE) begin
				if (go_seen)
					m_phase = life_pkg::SEQ_RUN;
			end else if (last) begin
				m_count = '0;
				m_base  = life_pkg::row_t'((int'(m_base) + 1) % `LIFE_BLOCKS_HIGH);
				if (!go_seen)
					m_phase = life_pkg::SEQ_IDLE;
			end else
				m_count = m_count + 8'd1;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Comparison at mid cycle
	////////////////////////////////////////////////////////////

	always @(negedge clk4) begin
		life_pkg::cell_win_t exp_win;
		logic [8:0]          exp_wr;
		logic                exp_ld;
		logic                run;
		step_model();
		go_seen  = go;
		rst_seen = reset;
		run = (m_phase == life_pkg::SEQ_RUN);
		win_q.push_back(ref_window(m_count, m_base, run, video_addr));
		wr_q.push_back({run, ref_waddr(m_count, m_base)});
		ld_q.push_back(video_load);
		if (we)
			wr_count++;
		if (ld)
			ld_count++;
		checks++;
		assert (gen_count === m_gen) else begin
			$display("ERR %0t gen_count exp %0d got %0d", $time, m_gen, gen_count);
			out_errors++;
		end
		if (win_q.size() > READ_LAT) begin
			exp_win = win_q.pop_front();
			assert (raddr === exp_win) else begin
				$display("ERR %0t raddr exp %h got %h", $time, exp_win, raddr);
				out_errors++;
			end
		end
		if (wr_q.size() > WRITE_LAT) begin
			exp_wr = wr_q.pop_front();
			assert (we === exp_wr[8]) else begin
				$display("ERR %0t we exp %b got %b", $time, exp_wr[8], we);
				out_errors++;
			end
			assert (!exp_wr[8] || waddr === exp_wr[7:0]) else begin
				$display("ERR %0t waddr exp %h got %h", $time, exp_wr[7:0], waddr);
				out_errors++;
			end
		end
		if (ld_q.size() > `LIFE_LOAD_DELAY) begin
			exp_ld = ld_q.pop_front();
			assert (ld === exp_ld) else begin
				$display("ERR %0t ld exp %b got %b", $time, exp_ld, ld);
				out_errors++;
			end
		end
	end

	always @(posedge clk4) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout, run still busy after %0d cycles", CYCLE_LIMIT);
			$display("Regression failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	task automatic next_cycle(); // Drive point 2 ns past the edge
		@(posedge clk4);
		#2;
		rand_byte(video_addr);
	endtask

	task automatic wait_gen(input int n);
		while (gen_count != life_pkg::gen_count_t'(n))
			next_cycle();
	endtask

	task automatic finish_generation(input int n);
		wait_gen(n);
		while (we) // Write-back tail
			next_cycle();
	endtask

	task automatic check_total(input string what, input int got, input int exp);
		assert (got == exp) else begin
			$display("%s: expected %0d, saw %0d", what, exp, got);
			seq_errors++;
		end
	endtask

	initial begin
		int wr_start;
		int ld_start;
		reset      = 1'b1;
		go         = 1'b0;
		video_addr = '0;
		video_load = 1'b0;
		repeat (5) @(posedge clk4);
		#2;
		reset = 1'b0;

		repeat (20) next_cycle(); // Quiet before any go
		assert (!we && !ld && gen_count == '0) else begin
			$display("Write, load or generation activity before any go");
			seq_errors++;
		end

		// Single pulse, base 1
		wr_start = wr_count;
		go = 1'b1;
		next_cycle();
		go = 1'b0;
		finish_generation(1);
		check_total("Writes in one generation", wr_count - wr_start, `LIFE_DONE_COUNT + 1);

		// Held go, bases 2 3 4
		wr_start = wr_count;
		go = 1'b1;
		wait_gen(3);
		go = 1'b0; // Fourth generation already started
		finish_generation(4);
		check_total("Writes in three generations", wr_count - wr_start,
			3 * (`LIFE_DONE_COUNT + 1));

		// Video block loads while idle
		ld_start = ld_count;
		for (int k = 0; k < 12; k++) begin
			video_load = 1'b1;
			next_cycle();
			video_load = 1'b0;
			repeat (2) next_cycle();
		end
		repeat (12) next_cycle();
		check_total("Load strobes", ld_count - ld_start, 12);

		$display("Checks %0d, output errors %0d, sequence errors %0d",
			checks, out_errors, seq_errors);
		if (out_errors == 0 && seq_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: life_addr_ctrl.f
+incdir+.
life_pkg.sv
gen_sequencer.sv
cell_addr_pipe.sv
cell_write_sched.sv
life_addr_ctrl.sv
tb_life_addr_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only on the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f life_addr_ctrl.f \
	--top-module tb_life_addr_ctrl -o sim_life

out=$(./obj_dir/sim_life)
echo "$out"
echo "$out" | grep -qx "Regression passed"
